/* Makefile */
TOP = tb_dither_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | awk '{print} /TEST PASS/{ok=1} END{exit !ok}'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir

/* bench/dither_assert.sv */
// protocol checks on the strobes between the sequencer, averagers and combiner.
// bound to dither_top, where those strobes are visible as wires and the FSM state via u_seq.
`default_nettype none

module dither_assert (
    input wire                    i_clk,
    input wire                    i_rst_n,
    input wire                    i_tick,
    input wire                    i_sample_h,
    input wire                    i_sample_l,
    input wire                    i_close_h,
    input wire                    i_close_l,
    input wire                    i_done_l,
    input wire                    i_valid,
    input dither_pkg::seq_state_t i_state
);
    timeunit 1ns;
    timeprecision 100ps;

    sample_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_sample_h && i_sample_l))
        else $error("both sample strobes high");

    sample_on_tick: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_sample_h || i_sample_l) |-> i_tick)
        else $error("sample strobe without a tick");

    close_h_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_close_h |=> !i_close_h)
        else $error("o_close_h longer than one cycle");

    close_l_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_close_l |=> !i_close_l)
        else $error("o_close_l longer than one cycle");

    // the low average must come out while the FSM still waits for it.
    done_in_combine: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done_l |-> (i_state == dither_pkg::S_COMBINE))
        else $error("low window done outside S_COMBINE");

    valid_after_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done_l |=> i_valid)
        else $error("o_valid missing after the low window done");

    valid_cause: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> $past(i_done_l))
        else $error("o_valid without a low window done");

endmodule

bind dither_top dither_assert u_assert (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_tick     (o_tick),
    .i_sample_h (sample_h),
    .i_sample_l (sample_l),
    .i_close_h  (close_h),
    .i_close_l  (close_l),
    .i_done_l   (done_l),
    .i_valid    (o_valid),
    .i_state    (u_seq.o_state)
);

`default_nettype wire

/* bench/tb_dither_top.sv */
// testbench for dither_top with a linear noisy plant and a reference model that follows the ports.
// expected results come from the observed samples, so config changes may land at any time.
`default_nettype none

module tb_dither_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'hb112_1b73;

    logic                                 i_clk;
    logic                                 i_rst_n;
    logic signed [dither_pkg::DATA_W-1:0] i_data;
    logic        [dither_pkg::CNT_W-1:0]  i_period;
    logic        [dither_pkg::CNT_W-1:0]  i_wait;
    logic        [dither_pkg::CNT_W-1:0]  i_avg_sel;
    logic signed [dither_pkg::DATA_W-1:0] i_dither_high;
    logic signed [dither_pkg::DATA_W-1:0] i_dither_low;
    wire                                  o_tick;
    wire  signed [dither_pkg::DATA_W-1:0] o_dither;
    wire  signed [dither_pkg::DATA_W-1:0] o_mean;
    wire  signed [dither_pkg::DATA_W-1:0] o_slope;
    wire                                  o_valid;

    logic [31:0] noise_rng;
    logic [31:0] cfg_rng;
    logic [31:0] cap_wait;        // config as seen at the last rising edge.
    logic [31:0] cap_sel;
    logic signed [31:0] cap_high;
    logic signed [31:0] cap_low;
    logic signed [31:0] lvl_low;
    logic signed [31:0] exp_dither;
    logic signed [31:0] prev_dither;
    logic signed [31:0] avg_h;
    logic signed [31:0] avg_l;
    logic signed [31:0] exp_mean;
    logic signed [31:0] exp_slope;
    logic signed [31:0] exp_mean_q[$];
    logic signed [31:0] exp_slope_q[$];
    logic        phase_high;
    logic        fresh_tick;
    longint      win_sum;
    int          lvl_wait;
    int          lvl_shift;
    int          discard;
    int          taken;
    int          since_step;
    int          trans_len;       // ticks of plant transient after each step.
    int          plant_off;
    int          n_checked;
    int          n;
    int          gap;

    dither_top dither_top_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_data        (i_data),
        .i_period      (i_period),
        .i_wait        (i_wait),
        .i_avg_sel     (i_avg_sel),
        .i_dither_high (i_dither_high),
        .i_dither_low  (i_dither_low),
        .o_tick        (o_tick),
        .o_dither      (o_dither),
        .o_mean        (o_mean),
        .o_slope       (o_slope),
        .o_valid       (o_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int clamp_sel(input logic [31:0] sel);
        return (sel > 32'd12) ? 7 : int'(sel);
    endfunction

    // reference: truncating boxcar average, then mean and half-difference of the two levels.
    function automatic logic signed [31:0] window_avg(input longint sum, input int shift);
        longint s;
        s = sum >>> shift;
        return s[31:0];
    endfunction

    function automatic logic signed [31:0] halve(input longint a, input longint b, input bit sub);
        longint s;
        s = sub ? (a - b) : (a + b);
        s = s >>> 1;
        return s[31:0];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wait_tick();
        int k;
        k = 0;
        do begin
            @(negedge i_clk);
            k++;
            if (k > 5000) fail_run("timed out waiting for o_tick");
        end while (!o_tick);
    endtask

    task automatic wait_results(input int count);
        int target;
        int k;
        target = n_checked + count;
        k = 0;
        while (n_checked < target) begin
            @(negedge i_clk);
            k++;
            if (k > 800000) fail_run("timed out waiting for o_valid");
        end
    endtask

    always @(posedge i_clk) begin
        cap_wait = i_wait;
        cap_sel  = i_avg_sel;
        cap_high = i_dither_high;
        cap_low  = i_dither_low;
    end

    // plant model and port-level tracking of the settle and acquire rule.
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            prev_dither = '0;
            phase_high  = 1'b0;
            taken       = 1;  // no window is open before the first level change.
            lvl_shift   = 0;
            discard     = 0;
        end else begin
            fresh_tick = (o_dither != prev_dither);
            if (fresh_tick) begin
                prev_dither = o_dither;
                phase_high  = !phase_high;
                if (phase_high) begin
                    lvl_wait   = int'(cap_wait);
                    lvl_shift  = clamp_sel(cap_sel);
                    lvl_low    = cap_low;
                    exp_dither = cap_high;
                end else begin
                    exp_dither = lvl_low;
                end
                assert (o_dither === exp_dither) else begin
                    $display("ERROR %0t o_dither expected %0d actual %0d",
                             $time, exp_dither, o_dither);
                    fail_run("o_dither level mismatch");
                end
                discard    = lvl_wait;
                taken      = 0;
                win_sum    = 0;
                since_step = 0;
            end
            if (o_tick) begin
                noise_rng = xorshift(noise_rng);
                i_data = 3 * o_dither + plant_off + int'($signed(noise_rng[11:0]))
                       + ((since_step < trans_len) ? 400000 : 0);
                if (!fresh_tick) begin
                    if (discard > 0) begin
                        discard--;
                    end else if (taken < (1 << lvl_shift)) begin
                        win_sum += longint'(i_data);
                        taken++;
                        if (taken == (1 << lvl_shift)) begin
                            if (phase_high) begin
                                avg_h = window_avg(win_sum, lvl_shift);
                            end else begin
                                avg_l = window_avg(win_sum, lvl_shift);
                                exp_mean_q.push_back(halve(avg_h, avg_l, 1'b0));
                                exp_slope_q.push_back(halve(avg_h, avg_l, 1'b1));
                            end
                        end
                    end
                end
                since_step++;
            end
        end
    end

    always @(negedge i_clk) begin
        if (i_rst_n && o_valid) begin
            if (exp_mean_q.size() == 0) begin
                fail_run("o_valid came before a full measurement cycle was seen");
            end else begin
                exp_mean  = exp_mean_q.pop_front();
                exp_slope = exp_slope_q.pop_front();
                assert (o_mean === exp_mean) else begin
                    $display("ERROR %0t o_mean expected %0d actual %0d", $time, exp_mean, o_mean);
                    fail_run("o_mean mismatch");
                end
                assert (o_slope === exp_slope) else begin
                    $display("ERROR %0t o_slope expected %0d actual %0d",
                             $time, exp_slope, o_slope);
                    fail_run("o_slope mismatch");
                end
                n_checked++;
            end
        end
    end

    initial begin
        i_rst_n       = 1'b0;
        i_data        = '0;
        i_period      = 32'd3;
        i_wait        = 32'd2;
        i_avg_sel     = 32'd3;
        i_dither_high = 10000;
        i_dither_low  = 2000;
        noise_rng     = SEED;
        cfg_rng       = xorshift(SEED);
        trans_len     = 0;
        plant_off     = 1000;
        n_checked     = 0;
        repeat (8) begin
            @(negedge i_clk);
            assert (!o_tick && !o_valid && o_dither == 0 && o_mean == 0 && o_slope == 0) else
                fail_run("outputs are not zero during reset");
        end
        i_rst_n = 1'b1;

        // first tick after the reset period.
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
            assert (!o_valid && o_mean == 0 && o_slope == 0) else
                fail_run("outputs changed before the first tick");
        end while (!o_tick && n < 1000);
        assert (n == int'(dither_pkg::RST_PERIOD) + 1) else begin
            $display("ERROR %0t first o_tick expected %0d actual %0d", $time,
                     int'(dither_pkg::RST_PERIOD) + 1, n);
            fail_run("first tick at the wrong cycle");
        end

        for (int p = 0; p < 4; p++) begin
            i_period = (p == 0) ? 32'd0 : (p == 1) ? 32'd5 : (p == 2) ? 32'd17 : 32'd2;
            wait_tick();
            wait_tick();
            gap = 0;
            do begin
                @(negedge i_clk);
                gap++;
                if (gap > 5000) fail_run("timed out measuring the tick spacing");
            end while (!o_tick);
            assert (gap == int'(i_period) + 1) else begin
                $display("ERROR %0t o_tick spacing expected %0d actual %0d", $time,
                         int'(i_period) + 1, gap);
                fail_run("tick spacing mismatch");
            end
        end

        // basic cycle with a small random period.
        cfg_rng   = xorshift(cfg_rng);
        i_period  = 32'd1 + (cfg_rng % 4);
        i_avg_sel = 32'd3;
        wait_results(3);

        i_period = 32'd1;
        for (int s = 0; s < 4; s++) begin
            i_avg_sel = (s == 0) ? 32'd0 : (s == 1) ? 32'd5 : (s == 2) ? 32'd12 : 32'd20;
            wait_results(2);
        end

        // plant transient after each step, with growing settle counts.
        trans_len = 3;
        i_avg_sel = 32'd2;
        for (int w = 0; w < 3; w++) begin
            i_wait = 32'(w * 3);
            wait_results(2);
        end

        trans_len     = 0;
        plant_off     = -70000;
        i_dither_high = -5000;
        i_dither_low  = -40000;
        i_avg_sel     = 32'd4;
        wait_results(3);

        if (n_checked >= 10 && exp_mean_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_run("too few results checked or results left unmatched");
        end
    end

endmodule

`default_nettype wire

/* design/dither_combiner.sv */
// mean and half-difference of the two level averages, no output saturation.
`default_nettype none

module dither_combiner (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_avg_h,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_avg_l,
    input  wire                                   i_done_l,
    output logic signed [dither_pkg::DATA_W-1:0]  o_mean,
    output logic signed [dither_pkg::DATA_W-1:0]  o_slope,
    output logic                                  o_valid
);

    // one guard bit so the sum and difference cannot wrap before halving.
    logic signed [dither_pkg::DATA_W:0] sum_w;
    logic signed [dither_pkg::DATA_W:0] diff_w;
    logic signed [dither_pkg::DATA_W:0] mean_w;
    logic signed [dither_pkg::DATA_W:0] slope_w;

    assign sum_w   = {i_avg_h[dither_pkg::DATA_W-1], i_avg_h}
                   + {i_avg_l[dither_pkg::DATA_W-1], i_avg_l};
    assign diff_w  = {i_avg_h[dither_pkg::DATA_W-1], i_avg_h}
                   - {i_avg_l[dither_pkg::DATA_W-1], i_avg_l};
    assign mean_w  = sum_w >>> 1;
    assign slope_w = diff_w >>> 1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mean  <= '0;
            o_slope <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_done_l;
            // the high average is settled long before the low window closes.
            if (i_done_l) begin
                o_mean  <= mean_w[dither_pkg::DATA_W-1:0];
                o_slope <= slope_w[dither_pkg::DATA_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/dither_pkg.sv */
// widths, limits and reset defaults for the dither measurement block.
// accumulators hold up to 2^AVG_SEL_MAX full-scale samples without overflow.
`default_nettype none

package dither_pkg;

    localparam int DATA_W  = 32;  // samples, dither levels and results.
    localparam int ACC_W   = 48;  // 4096 full-scale samples need 44 bits.
    localparam int CNT_W   = 32;
    localparam int SHIFT_W = 4;

    // the largest averaging exponent accepted on i_avg_sel.
    localparam logic [CNT_W-1:0] AVG_SEL_MAX = 32'd12;

    // this exponent replaces any i_avg_sel above AVG_SEL_MAX.
    localparam logic [SHIFT_W-1:0] AVG_SEL_DEFAULT = 4'd7;

    localparam logic [CNT_W-1:0] RST_PERIOD = 32'd100;  // first tick period after reset.

    // sequencer states, one settle and one acquire phase per dither level.
    typedef enum logic [3:0] {
        S_IDLE     = 4'd0,
        S_SET_H    = 4'd1,
        S_SETTLE_H = 4'd2,
        S_ACQ_H    = 4'd3,
        S_SET_L    = 4'd4,
        S_SETTLE_L = 4'd5,
        S_ACQ_L    = 4'd6,
        S_COMBINE  = 4'd7
    } seq_state_t;

endpackage

`default_nettype wire

/* design/dither_sequencer.sv */
// configuration is sampled once per cycle in S_SET_H and held until the next one.
// i_avg_sel above AVG_SEL_MAX falls back to AVG_SEL_DEFAULT, so averagers see a legal shift.
`default_nettype none

module dither_sequencer (
    input  wire                                  i_clk,
    input  wire                                  i_rst_n,
    input  wire        [dither_pkg::CNT_W-1:0]   i_period,
    input  wire        [dither_pkg::CNT_W-1:0]   i_wait,
    input  wire        [dither_pkg::CNT_W-1:0]   i_avg_sel,
    input  wire signed [dither_pkg::DATA_W-1:0]  i_dither_high,
    input  wire signed [dither_pkg::DATA_W-1:0]  i_dither_low,
    input  wire                                  i_done_l,
    output logic                                 o_tick,
    output logic signed [dither_pkg::DATA_W-1:0] o_dither,
    output logic       [dither_pkg::SHIFT_W-1:0] o_shift,
    output logic                                 o_sample_h,
    output logic                                 o_sample_l,
    output logic                                 o_close_h,
    output logic                                 o_close_l,
    output dither_pkg::seq_state_t               o_state
);

    dither_pkg::seq_state_t state;

    logic [dither_pkg::CNT_W-1:0]    tick_cnt;
    logic [dither_pkg::CNT_W-1:0]    cnt;      // settle count first, then sample count.
    logic [dither_pkg::CNT_W-1:0]    win_len;
    logic [dither_pkg::CNT_W-1:0]    wait_q;
    logic [dither_pkg::SHIFT_W-1:0]  shift_in;
    logic [dither_pkg::SHIFT_W-1:0]  shift_use;
    logic signed [dither_pkg::DATA_W-1:0] dither_low_q;
    logic fresh;    // first cycle on a new dither level.
    logic counted;
    logic last_sample;

    assign shift_in = (i_avg_sel > dither_pkg::AVG_SEL_MAX) ? dither_pkg::AVG_SEL_DEFAULT
                                                            : i_avg_sel[dither_pkg::SHIFT_W-1:0];

    // in S_SET_H the new exponent is not registered yet.
    assign shift_use = (state == dither_pkg::S_SET_H) ? shift_in : o_shift;
    assign win_len   = 1 << shift_use;

    // the tick that lands together with a level change belongs to neither window.
    assign counted     = o_tick && !fresh;
    assign o_sample_h  = counted && (state == dither_pkg::S_ACQ_H);
    assign o_sample_l  = counted && (state == dither_pkg::S_ACQ_L);
    assign last_sample = (o_sample_h || o_sample_l) && (cnt == 1);
    assign o_state     = state;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tick_cnt <= dither_pkg::RST_PERIOD;
            o_tick   <= 1'b0;
        end else if (tick_cnt == '0) begin
            tick_cnt <= i_period;  // ticks land i_period+1 cycles apart.
            o_tick   <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt - 1;
            o_tick   <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == dither_pkg::S_SET_H) begin
            wait_q       <= i_wait;
            dither_low_q <= i_dither_low;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= dither_pkg::S_IDLE;
            cnt       <= '0;
            fresh     <= 1'b0;
            o_dither  <= '0;
            o_shift   <= dither_pkg::AVG_SEL_DEFAULT;
            o_close_h <= 1'b0;
            o_close_l <= 1'b0;
        end else begin
            fresh     <= (state == dither_pkg::S_SET_H) || (state == dither_pkg::S_SET_L);
            o_close_h <= o_sample_h && (cnt == 1);  // one cycle after the last sample.
            o_close_l <= o_sample_l && (cnt == 1);
            case (state)
                dither_pkg::S_IDLE: begin
                    if (o_tick) state <= dither_pkg::S_SET_H;
                end
                dither_pkg::S_SET_H: begin
                    o_dither <= i_dither_high;
                    o_shift  <= shift_in;
                    if (i_wait == '0) begin
                        state <= dither_pkg::S_ACQ_H;
                        cnt   <= win_len;
                    end else begin
                        state <= dither_pkg::S_SETTLE_H;
                        cnt   <= i_wait;
                    end
                end
                dither_pkg::S_SETTLE_H, dither_pkg::S_SETTLE_L: begin
                    if (counted) begin
                        if (cnt == 1) begin
                            // last discarded tick, the window starts with the next one.
                            cnt   <= win_len;
                            state <= (state == dither_pkg::S_SETTLE_H) ? dither_pkg::S_ACQ_H
                                                                       : dither_pkg::S_ACQ_L;
                        end else begin
                            cnt <= cnt - 1;
                        end
                    end
                end
                dither_pkg::S_ACQ_H: begin
                    if (o_sample_h) cnt <= cnt - 1;
                    if (last_sample) state <= dither_pkg::S_SET_L;
                end
                dither_pkg::S_SET_L: begin
                    o_dither <= dither_low_q;
                    if (wait_q == '0) begin
                        state <= dither_pkg::S_ACQ_L;
                        cnt   <= win_len;
                    end else begin
                        state <= dither_pkg::S_SETTLE_L;
                        cnt   <= wait_q;
                    end
                end
                dither_pkg::S_ACQ_L: begin
                    if (o_sample_l) cnt <= cnt - 1;
                    if (last_sample) state <= dither_pkg::S_COMBINE;
                end
                dither_pkg::S_COMBINE: begin
                    if (i_done_l) state <= dither_pkg::S_SET_H;  // low average is out.
                end
                default: state <= dither_pkg::S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dither_top.sv */
// dither perturbation measurement, results are marked by a one-cycle o_valid.
// configuration inputs are taken at the start of each cycle only.
`default_nettype none

module dither_top (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_data,
    input  wire        [dither_pkg::CNT_W-1:0]    i_period,
    input  wire        [dither_pkg::CNT_W-1:0]    i_wait,
    input  wire        [dither_pkg::CNT_W-1:0]    i_avg_sel,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_dither_high,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_dither_low,
    output logic                                  o_tick,
    output logic signed [dither_pkg::DATA_W-1:0]  o_dither,
    output logic signed [dither_pkg::DATA_W-1:0]  o_mean,
    output logic signed [dither_pkg::DATA_W-1:0]  o_slope,
    output logic                                  o_valid
);

    logic [dither_pkg::SHIFT_W-1:0]       shift;
    logic                                 sample_h;
    logic                                 sample_l;
    logic                                 close_h;
    logic                                 close_l;
    logic                                 done_l;
    logic signed [dither_pkg::DATA_W-1:0] avg_h;
    logic signed [dither_pkg::DATA_W-1:0] avg_l;

    dither_sequencer u_seq (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_period      (i_period),
        .i_wait        (i_wait),
        .i_avg_sel     (i_avg_sel),
        .i_dither_high (i_dither_high),
        .i_dither_low  (i_dither_low),
        .i_done_l      (done_l),
        .o_tick        (o_tick),
        .o_dither      (o_dither),
        .o_shift       (shift),
        .o_sample_h    (sample_h),
        .o_sample_l    (sample_l),
        .o_close_h     (close_h),
        .o_close_l     (close_l),
        .o_state       ()
    );

    // the high average is picked up together with the low one.
    window_averager u_avg_h (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data   (i_data),
        .i_sample (sample_h),
        .i_close  (close_h),
        .i_shift  (shift),
        .o_avg    (avg_h),
        .o_done   ()
    );

    window_averager u_avg_l (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data   (i_data),
        .i_sample (sample_l),
        .i_close  (close_l),
        .i_shift  (shift),
        .o_avg    (avg_l),
        .o_done   (done_l)
    );

    dither_combiner u_comb (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_avg_h  (avg_h),
        .i_avg_l  (avg_l),
        .i_done_l (done_l),
        .o_mean   (o_mean),
        .o_slope  (o_slope),
        .o_valid  (o_valid)
    );

endmodule

`default_nettype wire

/* design/window_averager.sv */
// boxcar average over one window of strobed samples, divided by 2^i_shift.
// the result truncates toward minus infinity and is held until the next close.
`default_nettype none

module window_averager (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire signed [dither_pkg::DATA_W-1:0]   i_data,
    input  wire                                   i_sample,
    input  wire                                   i_close,
    input  wire        [dither_pkg::SHIFT_W-1:0]  i_shift,
    output logic signed [dither_pkg::DATA_W-1:0]  o_avg,
    output logic                                  o_done
);

    logic signed [dither_pkg::ACC_W-1:0] acc;
    logic signed [dither_pkg::ACC_W-1:0] data_ext;
    logic signed [dither_pkg::ACC_W-1:0] avg_full;

    assign data_ext = {{(dither_pkg::ACC_W-dither_pkg::DATA_W){i_data[dither_pkg::DATA_W-1]}},
                       i_data};

    assign avg_full = acc >>> i_shift;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= i_close;
            if (i_close) begin
                acc <= '0;  // next window starts empty.
            end else if (i_sample) begin
                acc <= acc + data_ext;
            end
        end
    end

    // the sum of 2^shift samples fits DATA_W again after the shift.
    always_ff @(posedge i_clk) begin
        if (i_close) o_avg <= avg_full[dither_pkg::DATA_W-1:0];
    end

endmodule

`default_nettype wire

/* vlog.f */
design/dither_pkg.sv
design/dither_sequencer.sv
design/window_averager.sv
design/dither_combiner.sv
design/dither_top.sv
bench/dither_assert.sv
bench/tb_dither_top.sv
